// ==== common/bp_cfg_pkg.sv ====
// ----------------------------------------------------------
// fetch geometry for the branch prediction block
// compressed instructions are always supported, so a fetch
// block of FETCH_BYTES holds INSTR_PER_FETCH halfword slots
// ----------------------------------------------------------

package bp_cfg_pkg;

  // ----------------------------------------------------------
  // address space
  // ----------------------------------------------------------

  // virtual address width (sv39)
  localparam int unsigned VLEN = 39;

  // ----------------------------------------------------------
  // fetch block layout
  // ----------------------------------------------------------

  // 16-bit slots per 32-bit fetch block
  localparam int unsigned INSTR_PER_FETCH = 2;
  // bits needed to pick a slot inside the block
  localparam int unsigned SLOT_BITS = 1;
  // bytes fetched per cycle, step of the sequential pc
  localparam int unsigned FETCH_BYTES = 4;

  // ----------------------------------------------------------
  // index offsets
  // ----------------------------------------------------------

  // pc bit 0 is always zero with halfword alignment
  localparam int unsigned PC_OFFSET = 1;
  // lowest pc bit of a table row index, just above the slot bit
  localparam int unsigned ROW_LSB = PC_OFFSET + SLOT_BITS;

endpackage

// ==== common/bp_types_pkg.sv ====
// ----------------------------------------------------------
// entry types of the history and target tables
// a counter value of 2'b1x predicts taken
// evicted counters restart at weakly taken
// ----------------------------------------------------------

package bp_types_pkg;

  // ----------------------------------------------------------
  // saturating counter
  // ----------------------------------------------------------

  // ordered so that +1 moves toward taken
  typedef enum logic [1:0] {
    CNT_STRONG_NT = 2'b00,
    CNT_WEAK_NT   = 2'b01,
    CNT_WEAK_T    = 2'b10,
    CNT_STRONG_T  = 2'b11
  } sat_cnt_t;

  // value after reset, flush or clear
  localparam sat_cnt_t CNT_RESET = CNT_WEAK_T;

  // ----------------------------------------------------------
  // table entries
  // ----------------------------------------------------------

  // one history entry, 3 bits
  typedef struct packed {
    logic     valid;
    sat_cnt_t cnt;
  } bht_entry_t;

  // one target entry, full virtual target
  typedef struct packed {
    logic                         valid;
    logic [bp_cfg_pkg::VLEN-1:0] target;
  } btb_entry_t;

endpackage

// ==== bht/bht.sv ====
// ----------------------------------------------------------
// branch history table, 2-bit saturating counter per slot
// BHT_ENTRIES is a power of two and at least 4
// prediction reads are combinational, updates land at the
// next edge, and flush or clear evicts all rows in one cycle
// ----------------------------------------------------------

`timescale 1ns/1ps

module bht #(
  parameter int unsigned BHT_ENTRIES = 1024,
  parameter bit          DEBUG_EN    = 1'b1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  logic                                  flush_i,
  input  logic                                  debug_mode_i,
  // fetch address, halfword aligned
  input  logic [bp_cfg_pkg::VLEN-1:0]            vpc_i,
  // resolved branch from execute
  input  logic                                  bht_update_valid_i,
  input  logic                                  bht_update_taken_i,
  input  logic [bp_cfg_pkg::VLEN-1:0]            bht_update_pc_i,
  // state of the fetched row, one bit per slot
  output logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] bht_valid_o,
  output logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] bht_taken_o
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  // ----------------------------------------------------------
  // geometry
  // ----------------------------------------------------------

  // table reshaped into rows of one fetch block each
  localparam int unsigned NR_ROWS  = BHT_ENTRIES / INSTR_PER_FETCH;
  localparam int unsigned ROW_BITS = $clog2(NR_ROWS);

  // entry state after eviction
  localparam bht_entry_t EVICT_ENTRY = '{valid: 1'b0, cnt: CNT_RESET};

  // ----------------------------------------------------------
  // storage and indexing
  // ----------------------------------------------------------

  bht_entry_t bht_q [NR_ROWS][INSTR_PER_FETCH];

  logic [ROW_BITS-1:0]  rd_row;
  logic [ROW_BITS-1:0]  upd_row;
  logic [SLOT_BITS-1:0] upd_slot;
  logic                 upd_en;
  bht_entry_t           upd_entry;

  // row from the bits just above the slot bit
  assign rd_row   = vpc_i[ROW_LSB +: ROW_BITS];
  assign upd_row  = bht_update_pc_i[ROW_LSB +: ROW_BITS];
  // slot from pc bit 1
  assign upd_slot = bht_update_pc_i[PC_OFFSET +: SLOT_BITS];

  // updates are dropped in debug mode only when debug support is built in
  assign upd_en = bht_update_valid_i & ~(DEBUG_EN & debug_mode_i);

  // ----------------------------------------------------------
  // counter step
  // ----------------------------------------------------------

  // one step toward the outcome, holds at both ends
  function automatic sat_cnt_t cnt_step(input sat_cnt_t cnt, input logic taken);
    sat_cnt_t nxt;
    nxt = cnt;
    case (cnt)
      CNT_STRONG_NT: nxt = taken ? CNT_WEAK_NT : CNT_STRONG_NT;
      CNT_WEAK_NT:   nxt = taken ? CNT_WEAK_T : CNT_STRONG_NT;
      CNT_WEAK_T:    nxt = taken ? CNT_STRONG_T : CNT_WEAK_NT;
      CNT_STRONG_T:  nxt = taken ? CNT_STRONG_T : CNT_WEAK_T;
      default:       nxt = CNT_RESET;
    endcase
    return nxt;
  endfunction

  // read-modify-write value for the updated entry
  // an invalid entry steps from its evicted counter value
  always_comb begin
    upd_entry.valid = 1'b1;
    upd_entry.cnt   = cnt_step(bht_q[upd_row][upd_slot].cnt, bht_update_taken_i);
  end

  // ----------------------------------------------------------
  // prediction read
  // ----------------------------------------------------------

  // taken is the counter's upper bit, not gated by valid
  for (genvar s = 0; s < INSTR_PER_FETCH; s++) begin : gen_rd
    assign bht_valid_o[s] = bht_q[rd_row][s].valid;
    assign bht_taken_o[s] = bht_q[rd_row][s].cnt[1];
  end

  // ----------------------------------------------------------
  // table flops
  // ----------------------------------------------------------

  // a read of the entry being updated still sees the old value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          bht_q[r][s] <= EVICT_ENTRY;
        end
      end
    end else if (flush_i || clear_i) begin
      // evict everything, wins over a same-cycle update
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          bht_q[r][s] <= EVICT_ENTRY;
        end
      end
    end else if (upd_en) begin
      bht_q[upd_row][upd_slot] <= upd_entry;
    end
  end

endmodule

// ==== btb/btb.sv ====
// ----------------------------------------------------------
// branch target buffer, one full target per fetch slot
// BTB_ENTRIES is a power of two and at least 4
// there is no tag, so aliased pcs share an entry
// flush or clear drops every valid bit in one cycle
// ----------------------------------------------------------

`timescale 1ns/1ps

module btb #(
  parameter int unsigned BTB_ENTRIES = 64,
  parameter bit          DEBUG_EN    = 1'b1
) (
  input  logic                                                         clk_i,
  input  logic                                                         rst_ni,
  input  logic                                                         clear_i,
  input  logic                                                         flush_i,
  input  logic                                                         debug_mode_i,
  // fetch address, halfword aligned
  input  logic [bp_cfg_pkg::VLEN-1:0]                                   vpc_i,
  // resolved target from execute
  input  logic                                                         btb_update_valid_i,
  input  logic [bp_cfg_pkg::VLEN-1:0]                                   btb_update_pc_i,
  input  logic [bp_cfg_pkg::VLEN-1:0]                                   btb_update_target_i,
  // per-slot hit and target of the fetched row
  output logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0]                        btb_hit_o,
  output logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0][bp_cfg_pkg::VLEN-1:0] btb_target_o
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  // ----------------------------------------------------------
  // geometry
  // ----------------------------------------------------------

  localparam int unsigned NR_ROWS  = BTB_ENTRIES / INSTR_PER_FETCH;
  localparam int unsigned ROW_BITS = $clog2(NR_ROWS);

  // ----------------------------------------------------------
  // storage and indexing
  // ----------------------------------------------------------

  btb_entry_t btb_q [NR_ROWS][INSTR_PER_FETCH];

  logic [ROW_BITS-1:0]  rd_row;
  logic [ROW_BITS-1:0]  upd_row;
  logic [SLOT_BITS-1:0] upd_slot;
  logic                 upd_en;
  btb_entry_t           upd_entry;

  // same index rule as the history table
  assign rd_row   = vpc_i[ROW_LSB +: ROW_BITS];
  assign upd_row  = btb_update_pc_i[ROW_LSB +: ROW_BITS];
  assign upd_slot = btb_update_pc_i[PC_OFFSET +: SLOT_BITS];

  // no writes while the core sits in debug mode
  assign upd_en = btb_update_valid_i & ~(DEBUG_EN & debug_mode_i);

  // new entry is always valid
  assign upd_entry = '{valid: 1'b1, target: btb_update_target_i};

  // ----------------------------------------------------------
  // prediction read
  // ----------------------------------------------------------

  for (genvar s = 0; s < INSTR_PER_FETCH; s++) begin : gen_rd
    assign btb_hit_o[s]    = btb_q[rd_row][s].valid;
    assign btb_target_o[s] = btb_q[rd_row][s].target;
  end

  // ----------------------------------------------------------
  // table flops
  // ----------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          btb_q[r][s] <= '0;
        end
      end
    end else if (flush_i || clear_i) begin
      // targets stay, only the valid bits go
      for (int r = 0; r < NR_ROWS; r++) begin
        for (int s = 0; s < INSTR_PER_FETCH; s++) begin
          btb_q[r][s].valid <= 1'b0;
        end
      end
    end else if (upd_en) begin
      // same-cycle read of this entry returns the old target
      btb_q[upd_row][upd_slot] <= upd_entry;
    end
  end

endmodule

// ==== rtl/next_pc_select.sv ====
// ----------------------------------------------------------
// next fetch pc from the per-slot table state
// purely combinational, zero cycles from vpc_i
// slots before the one vpc_i starts in are never taken
// ----------------------------------------------------------

`timescale 1ns/1ps

module next_pc_select (
  input  logic [bp_cfg_pkg::VLEN-1:0]                                   vpc_i,
  // predecode found a conditional branch in the slot
  input  logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0]                        branch_mask_i,
  input  logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0]                        bht_valid_i,
  input  logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0]                        bht_taken_i,
  input  logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0]                        btb_hit_i,
  input  logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0][bp_cfg_pkg::VLEN-1:0] btb_target_i,
  output logic                                                         predict_taken_o,
  output logic [bp_cfg_pkg::SLOT_BITS-1:0]                              predict_slot_o,
  output logic [bp_cfg_pkg::VLEN-1:0]                                   next_pc_o
);

  import bp_cfg_pkg::*;

  // low pc bits cleared to align to the fetch block
  localparam int unsigned ALIGN_BITS = $clog2(FETCH_BYTES);

  logic [SLOT_BITS-1:0]       start_slot;
  logic [INSTR_PER_FETCH-1:0] cand;
  logic [VLEN-1:0]            seq_pc;

  // slot the fetch starts in, pc bit 1
  assign start_slot = vpc_i[PC_OFFSET +: SLOT_BITS];

  // sequential address of the next block
  assign seq_pc = {vpc_i[VLEN-1:ALIGN_BITS], {ALIGN_BITS{1'b0}}} + VLEN'(FETCH_BYTES);

  // ----------------------------------------------------------
  // candidate slots
  // ----------------------------------------------------------

  // branch here, counter valid and taken, target known
  for (genvar s = 0; s < INSTR_PER_FETCH; s++) begin : gen_cand
    assign cand[s] = (s >= int'(start_slot)) & branch_mask_i[s] &
                     bht_valid_i[s] & bht_taken_i[s] & btb_hit_i[s];
  end

  // ----------------------------------------------------------
  // priority pick
  // ----------------------------------------------------------

  // walk downward so the lowest candidate is the last to win
  always_comb begin
    predict_taken_o = 1'b0;
    predict_slot_o  = '0;
    next_pc_o       = seq_pc;
    for (int s = INSTR_PER_FETCH - 1; s >= 0; s--) begin
      if (cand[s]) begin
        predict_taken_o = 1'b1;
        predict_slot_o  = SLOT_BITS'(s);
        next_pc_o       = btb_target_i[s];
      end
    end
  end

endmodule

// ==== rtl/branch_predictor.sv ====
// ----------------------------------------------------------
// branch prediction top, history table + target buffer
// prediction is combinational from vpc_i and branch_mask_i
// updates are one-cycle pulses with no back-pressure
// ----------------------------------------------------------

`timescale 1ns/1ps

module branch_predictor #(
  parameter int unsigned BHT_ENTRIES = 1024,
  parameter int unsigned BTB_ENTRIES = 64,
  parameter bit          DEBUG_EN    = 1'b1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear_i,
  input  logic                                  flush_i,
  input  logic                                  debug_mode_i,
  // fetch side
  input  logic [bp_cfg_pkg::VLEN-1:0]            vpc_i,
  input  logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] branch_mask_i,
  // execute side, history update
  input  logic                                  bht_update_valid_i,
  input  logic [bp_cfg_pkg::VLEN-1:0]            bht_update_pc_i,
  input  logic                                  bht_update_taken_i,
  // execute side, target update
  input  logic                                  btb_update_valid_i,
  input  logic [bp_cfg_pkg::VLEN-1:0]            btb_update_pc_i,
  input  logic [bp_cfg_pkg::VLEN-1:0]            btb_update_target_i,
  // prediction
  output logic                                  predict_taken_o,
  output logic [bp_cfg_pkg::SLOT_BITS-1:0]       predict_slot_o,
  output logic [bp_cfg_pkg::VLEN-1:0]            next_pc_o,
  // fetched row counter state for performance counters
  output logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] bht_valid_o,
  output logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] bht_taken_o
);

  import bp_cfg_pkg::*;

  // target buffer to selector
  logic [INSTR_PER_FETCH-1:0]           btb_hit;
  logic [INSTR_PER_FETCH-1:0][VLEN-1:0] btb_target;

  // ----------------------------------------------------------
  // tables
  // ----------------------------------------------------------

  bht #(
    .BHT_ENTRIES(BHT_ENTRIES),
    .DEBUG_EN   (DEBUG_EN)
  ) i_bht (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clear_i           (clear_i),
    .flush_i           (flush_i),
    .debug_mode_i      (debug_mode_i),
    .vpc_i             (vpc_i),
    .bht_update_valid_i(bht_update_valid_i),
    .bht_update_taken_i(bht_update_taken_i),
    .bht_update_pc_i   (bht_update_pc_i),
    .bht_valid_o       (bht_valid_o),
    .bht_taken_o       (bht_taken_o)
  );

  btb #(
    .BTB_ENTRIES(BTB_ENTRIES),
    .DEBUG_EN   (DEBUG_EN)
  ) i_btb (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .clear_i            (clear_i),
    .flush_i            (flush_i),
    .debug_mode_i       (debug_mode_i),
    .vpc_i              (vpc_i),
    .btb_update_valid_i (btb_update_valid_i),
    .btb_update_pc_i    (btb_update_pc_i),
    .btb_update_target_i(btb_update_target_i),
    .btb_hit_o          (btb_hit),
    .btb_target_o       (btb_target)
  );

  // ----------------------------------------------------------
  // next pc
  // ----------------------------------------------------------

  next_pc_select i_next_pc_select (
    .vpc_i          (vpc_i),
    .branch_mask_i  (branch_mask_i),
    .bht_valid_i    (bht_valid_o),
    .bht_taken_i    (bht_taken_o),
    .btb_hit_i      (btb_hit),
    .btb_target_i   (btb_target),
    .predict_taken_o(predict_taken_o),
    .predict_slot_o (predict_slot_o),
    .next_pc_o      (next_pc_o)
  );

endmodule

// ==== tests/branch_predictor_properties.sv ====
// ----------------------------------------------------------
// concurrent checks bound to every branch_predictor
// all checks are off while rst_ni is low
// ----------------------------------------------------------

`timescale 1ns/1ps

module branch_predictor_properties (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  flush_i,
  input logic                                  clear_i,
  input logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] branch_mask_i,
  input logic                                  predict_taken_i,
  input logic [bp_cfg_pkg::SLOT_BITS-1:0]       predict_slot_i,
  input logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] bht_valid_i,
  input logic [bp_cfg_pkg::INSTR_PER_FETCH-1:0] bht_taken_i
);

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  // evicted counters all read back as weakly taken
  localparam logic [INSTR_PER_FETCH-1:0] EVICT_TAKEN = {INSTR_PER_FETCH{CNT_RESET[1]}};

  // every entry is invalid right after an eviction
  a_no_pred_after_evict : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (flush_i || clear_i) |=> !predict_taken_i)
    else $error("prediction in the cycle after flush or clear");

  // only a predecoded branch slot may redirect fetch
  a_pred_on_branch : assert property (@(posedge clk_i) disable iff (!rst_ni)
      predict_taken_i |-> branch_mask_i[predict_slot_i])
    else $error("predicted slot holds no branch");

  // fetched row is invalid and back at the reset counter after eviction
  a_row_evicted : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (flush_i || clear_i) |=> (bht_valid_i == '0 && bht_taken_i == EVICT_TAKEN))
    else $error("fetched row not evicted after flush or clear");

endmodule

bind branch_predictor branch_predictor_properties i_properties (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .flush_i        (flush_i),
  .clear_i        (clear_i),
  .branch_mask_i  (branch_mask_i),
  .predict_taken_i(predict_taken_o),
  .predict_slot_i (predict_slot_o),
  .bht_valid_i    (bht_valid_o),
  .bht_taken_i    (bht_taken_o)
);

// ==== tests/tb_branch_predictor.sv ====
// ----------------------------------------------------------
// random testbench for branch_predictor with small tables
// inputs change on the rising edge, outputs are compared on
// the falling edge against a model of both tables
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_branch_predictor;

  import bp_cfg_pkg::*;
  import bp_types_pkg::*;

  localparam int unsigned BHT_ENTRIES   = 16;
  localparam int unsigned BTB_ENTRIES   = 8;
  localparam bit          DEBUG_EN      = 1'b1;
  localparam int unsigned BHT_RB        = $clog2(BHT_ENTRIES / INSTR_PER_FETCH);
  localparam int unsigned BTB_RB        = $clog2(BTB_ENTRIES / INSTR_PER_FETCH);
  localparam int unsigned N_CYCLES      = 6000;
  localparam int unsigned QUIET_TIMEOUT = 20;

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni;
  logic                                 clear_i;
  logic                                 flush_i;
  logic                                 debug_mode_i;
  logic [VLEN-1:0]                      vpc_i;
  logic [INSTR_PER_FETCH-1:0]           branch_mask_i;
  logic                                 bht_update_valid_i;
  logic [VLEN-1:0]                      bht_update_pc_i;
  logic                                 bht_update_taken_i;
  logic                                 btb_update_valid_i;
  logic [VLEN-1:0]                      btb_update_pc_i;
  logic [VLEN-1:0]                      btb_update_target_i;
  logic                                 predict_taken_o;
  logic [SLOT_BITS-1:0]                 predict_slot_o;
  logic [VLEN-1:0]                      next_pc_o;
  logic [INSTR_PER_FETCH-1:0]           bht_valid_o;
  logic [INSTR_PER_FETCH-1:0]           bht_taken_o;

  // ----------------------------------------------------------
  // model state and stimulus pool
  // ----------------------------------------------------------

  logic [1:0]      m_cnt [2**BHT_RB][INSTR_PER_FETCH];
  logic            m_bv  [2**BHT_RB][INSTR_PER_FETCH];
  logic            m_tv  [2**BTB_RB][INSTR_PER_FETCH];
  logic [VLEN-1:0] m_tgt [2**BTB_RB][INSTR_PER_FETCH];
  // few pcs so that rows are hit again and again
  logic [VLEN-1:0] pool [8];
  logic [VLEN-1:0] last_bht_pc;
  integer          seed;

  always #5 clk_i = ~clk_i;

  branch_predictor #(
    .BHT_ENTRIES(BHT_ENTRIES),
    .BTB_ENTRIES(BTB_ENTRIES),
    .DEBUG_EN   (DEBUG_EN)
  ) UUT (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .clear_i            (clear_i),
    .flush_i            (flush_i),
    .debug_mode_i       (debug_mode_i),
    .vpc_i              (vpc_i),
    .branch_mask_i      (branch_mask_i),
    .bht_update_valid_i (bht_update_valid_i),
    .bht_update_pc_i    (bht_update_pc_i),
    .bht_update_taken_i (bht_update_taken_i),
    .btb_update_valid_i (btb_update_valid_i),
    .btb_update_pc_i    (btb_update_pc_i),
    .btb_update_target_i(btb_update_target_i),
    .predict_taken_o    (predict_taken_o),
    .predict_slot_o     (predict_slot_o),
    .next_pc_o          (next_pc_o),
    .bht_valid_o        (bht_valid_o),
    .bht_taken_o        (bht_taken_o)
  );

  // ----------------------------------------------------------
  // checking
  // ----------------------------------------------------------

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      stop_on_failure();
    end
  endtask

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  task automatic model_evict();
    for (int r = 0; r < 2**BHT_RB; r++) begin
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        m_cnt[r][s] = CNT_RESET;
        m_bv[r][s]  = 1'b0;
      end
    end
    for (int r = 0; r < 2**BTB_RB; r++) begin
      for (int s = 0; s < INSTR_PER_FETCH; s++) begin
        m_tv[r][s]  = 1'b0;
        m_tgt[r][s] = '0;
      end
    end
  endtask

  // called at a rising edge, before new inputs are driven
  task automatic model_edge();
    logic [BHT_RB-1:0]    hr;
    logic [BTB_RB-1:0]    tr;
    logic [SLOT_BITS-1:0] hs;
    logic [SLOT_BITS-1:0] ts;
    logic                 blocked;
    hr      = bht_update_pc_i[ROW_LSB +: BHT_RB];
    hs      = bht_update_pc_i[PC_OFFSET +: SLOT_BITS];
    tr      = btb_update_pc_i[ROW_LSB +: BTB_RB];
    ts      = btb_update_pc_i[PC_OFFSET +: SLOT_BITS];
    blocked = DEBUG_EN && debug_mode_i;
    if (flush_i || clear_i) begin
      model_evict();
    end else begin
      if (bht_update_valid_i && !blocked) begin
        m_bv[hr][hs] = 1'b1;
        // saturate at 0 and 3
        if (bht_update_taken_i && m_cnt[hr][hs] != 2'd3) begin
          m_cnt[hr][hs] = m_cnt[hr][hs] + 2'd1;
        end else if (!bht_update_taken_i && m_cnt[hr][hs] != 2'd0) begin
          m_cnt[hr][hs] = m_cnt[hr][hs] - 2'd1;
        end
      end
      if (btb_update_valid_i && !blocked) begin
        m_tv[tr][ts]  = 1'b1;
        m_tgt[tr][ts] = btb_update_target_i;
      end
    end
  endtask

  task automatic check_outputs();
    logic [BHT_RB-1:0]          hr;
    logic [BTB_RB-1:0]          tr;
    logic                       exp_taken;
    logic [SLOT_BITS-1:0]       exp_slot;
    logic [VLEN-1:0]            exp_pc;
    logic [INSTR_PER_FETCH-1:0] exp_v;
    logic [INSTR_PER_FETCH-1:0] exp_t;
    hr        = vpc_i[ROW_LSB +: BHT_RB];
    tr        = vpc_i[ROW_LSB +: BTB_RB];
    exp_taken = 1'b0;
    exp_slot  = '0;
    // next block when nothing qualifies
    exp_pc    = {vpc_i[VLEN-1:2], 2'b00} + VLEN'(FETCH_BYTES);
    for (int s = 0; s < INSTR_PER_FETCH; s++) begin
      exp_v[s] = m_bv[hr][s];
      exp_t[s] = m_cnt[hr][s][1];
      // first qualifying slot at or after the start slot
      if (!exp_taken && s >= int'(vpc_i[PC_OFFSET]) && branch_mask_i[s] &&
          m_bv[hr][s] && m_cnt[hr][s][1] && m_tv[tr][s]) begin
        exp_taken = 1'b1;
        exp_slot  = SLOT_BITS'(s);
        exp_pc    = m_tgt[tr][s];
      end
    end
    check_value("bht_valid_o", 64'(exp_v), 64'(bht_valid_o));
    check_value("bht_taken_o", 64'(exp_t), 64'(bht_taken_o));
    check_value("predict_taken_o", 64'(exp_taken), 64'(predict_taken_o));
    check_value("predict_slot_o", 64'(exp_slot), 64'(predict_slot_o));
    check_value("next_pc_o", 64'(exp_pc), 64'(next_pc_o));
  endtask

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  // taken_bias high favours taken outcomes, low favours not taken
  task automatic drive_random(input logic taken_bias);
    logic [31:0]     r;
    logic [31:0]     r2;
    logic [31:0]     r3;
    logic [VLEN-1:0] upd_pc;
    r      = $random(seed);
    r2     = $random(seed);
    r3     = $random(seed);
    upd_pc = pool[r[10:8]];
    // often fetch the row that was just updated
    vpc_i               <= r[31] ? last_bht_pc : pool[r[2:0]];
    branch_mask_i       <= r[4:3];
    bht_update_valid_i  <= (r[7:5] != 3'd0);
    bht_update_pc_i     <= upd_pc;
    bht_update_taken_i  <= taken_bias ? (r[12:11] != 2'd0) : (r[12:11] == 2'd0);
    btb_update_valid_i  <= r[13];
    btb_update_pc_i     <= pool[r[16:14]];
    btb_update_target_i <= {r2[22:16], r3[31:1], 1'b0};
    debug_mode_i        <= (r2[3:0] == 4'd0);
    flush_i             <= (r2[9:4] == 6'd0);
    clear_i             <= (r2[15:10] == 6'd0);
    last_bht_pc         = upd_pc;
  endtask

  initial begin
    logic [31:0] r;
    int unsigned waited;
    rst_ni              <= 1'b0;
    clear_i             <= 1'b0;
    flush_i             <= 1'b0;
    debug_mode_i        <= 1'b0;
    vpc_i               <= '0;
    branch_mask_i       <= '0;
    bht_update_valid_i  <= 1'b0;
    bht_update_pc_i     <= '0;
    bht_update_taken_i  <= 1'b0;
    btb_update_valid_i  <= 1'b0;
    btb_update_pc_i     <= '0;
    btb_update_target_i <= '0;
    seed = 32'h3d45263d;
    for (int i = 0; i < 8; i++) begin
      r       = $random(seed);
      pool[i] = VLEN'(32'h8000 | (r & 32'h103e));
    end
    last_bht_pc = pool[0];
    model_evict();

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // wait for the idle reset state, bounded
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > QUIET_TIMEOUT) begin
        $display("timeout: predictor never showed an empty table after reset");
        stop_on_failure();
      end
    end while (bht_valid_o !== '0 || predict_taken_o !== 1'b0);

    // reset counters read weakly taken on every slot
    check_value("bht_taken_o", 64'({INSTR_PER_FETCH{CNT_RESET[1]}}), 64'(bht_taken_o));
    check_outputs();

    for (int unsigned c = 0; c < N_CYCLES; c++) begin
      @(posedge clk_i);
      model_edge();
      drive_random(c < N_CYCLES / 2);
      @(negedge clk_i);
      check_outputs();
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
common/bp_cfg_pkg.sv
common/bp_types_pkg.sv
bht/bht.sv
btb/btb.sv
rtl/next_pc_select.sv
rtl/branch_predictor.sv
tests/branch_predictor_properties.sv
tests/tb_branch_predictor.sv

// ==== Makefile ====
# Verilator build of the branch predictor testbench
# the run target fails whenever the simulation ends in $fatal

TOP := tb_branch_predictor
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f compile.f \
		--top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)
